// ==== sim/rvDecodeExec_patterns.txt ====
# instr rs1Data rs2Data pc aluResult pcNext regWrite memWrite illegal, all in hex
# aluResult is not checked on lines with illegal set
002081B3 12345678 11111111 00001000 23456789 00001004 1 0 0
402081B3 00000010 00000030 00001004 FFFFFFE0 00001008 1 0 0
0020F1B3 F0F0FF00 0FF0F0F0 00001008 00F0F000 0000100C 1 0 0
0020E1B3 F0F0FF00 0FF0F0F0 0000100C FFF0FFF0 00001010 1 0 0
0020A1B3 FFFFFFF0 00000005 00001010 00000001 00001014 1 0 0
FFC08193 00000100 DEADBEEF 00001014 000000FC 00001018 1 0 0
0FF0F193 12345678 00000000 00001018 00000078 0000101C 1 0 0
8000E193 0000001F 00000000 0000101C FFFFF81F 00001020 1 0 0
0050A193 FFFFFFFF 00000000 00001020 00000001 00001024 1 0 0
0080A183 00002000 00000000 00001024 00002008 00001028 1 0 0
FE20AA23 00003000 CAFEF00D 00001028 00002FF4 0000102C 0 1 0
00208863 00000055 00000055 00000100 00000000 00000110 0 0 0
00208863 00000055 00000054 00000104 00000001 00000108 0 0 0
FE208CE3 FFFFFFFF FFFFFFFF 00000200 00000000 000001F8 0 0 0
001000EF 00000000 00000000 00000400 00000404 00000C00 1 0 0
FFDFF06F 00000000 00000000 00001000 00001004 00000FFC 1 0 0
ABCDE2B7 11111111 22222222 00000020 ABCDE000 00000024 1 0 0
FFFFFFFF 00000001 00000002 00000300 00000000 00000304 0 0 1
00001097 00000000 00000000 00000310 00000000 00000314 0 0 1

// ==== rvDecodeExec.f ====
logic/rvCorePkg.sv
logic/immSrcDec.sv
logic/mainDecoder.sv
logic/aluDecoder.sv
logic/immExtend.sv
logic/executeStage.sv
logic/rvDecodeExec.sv
sim/rvDecodeExec_asserts.sv
sim/rvDecodeExecTb.sv

// ==== Makefile ====
TOP = rvDecodeExecTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) \
		-f rvDecodeExec.f -o simv
	out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -Wall --top-module $(TOP) \
		-f rvDecodeExec.f

clean:
	rm -rf obj_dir

// ==== sim/rvDecodeExecTb.sv ====
// reads sim/rvDecodeExec_patterns.txt relative to the project root and expects the bound asserts
`timescale 1ns/10ps
`default_nettype none

module rvDecodeExecTb;

    // one line of the pattern file
    typedef struct packed {
        rvCorePkg::word_t instr;
        rvCorePkg::word_t rs1Data;
        rvCorePkg::word_t rs2Data;
        rvCorePkg::word_t pc;
        rvCorePkg::word_t expAlu;
        rvCorePkg::word_t expPcNext;
        logic             regWrite;
        logic             memWrite;
        logic             illegal;
    } pattern_t;

    logic                clk;
    logic                rstN;
    logic                instrValid;
    rvCorePkg::word_t    instr;
    rvCorePkg::word_t    rs1Data;
    rvCorePkg::word_t    rs2Data;
    rvCorePkg::word_t    pc;
    logic                outValid;
    rvCorePkg::execOut_t out;

    pattern_t patterns[$];
    int       errorCount = 0;
    int       checkCount = 0;
    int       strobeCount = 0;
    int       validCount = 0;
    logic     aborted = 1'b0;

    rvDecodeExec dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .pc         (pc),
        .outValid   (outValid),
        .out        (out)
    );

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // count result strobes where outputs are stable
    always @(negedge clk)
    begin
        if (outValid)
            validCount++;
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("FAIL at %0t ns: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // loads write back memory data and jal the link address
    function automatic rvCorePkg::resultSrc_t expectedResultSrc(input rvCorePkg::word_t ins);
        case (ins[6:0])
            rvCorePkg::opLoad:
                return rvCorePkg::resMem;
            rvCorePkg::opJal:
                return rvCorePkg::resPcPlus4;
            default:
                return rvCorePkg::resAlu;
        endcase
    endfunction

    task automatic loadPatterns();
        int          fd;
        int          code;
        string       line;
        pattern_t    p;
        logic [31:0] cInstr, cRs1, cRs2, cPc, cAlu, cPcNext;
        logic [31:0] cRegWrite, cMemWrite, cIllegal;
        fd = $fopen("sim/rvDecodeExec_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open the pattern file sim/rvDecodeExec_patterns.txt");
            aborted = 1'b1;
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fgets(line, fd);
                if (code != 0)
                begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h", cInstr, cRs1, cRs2,
                                   cPc, cAlu, cPcNext, cRegWrite, cMemWrite, cIllegal);
                    // comment and blank lines give no fields
                    if (code == 9)
                    begin
                        p.instr     = cInstr;
                        p.rs1Data   = cRs1;
                        p.rs2Data   = cRs2;
                        p.pc        = cPc;
                        p.expAlu    = cAlu;
                        p.expPcNext = cPcNext;
                        p.regWrite  = cRegWrite[0];
                        p.memWrite  = cMemWrite[0];
                        p.illegal   = cIllegal[0];
                        patterns.push_back(p);
                    end
                end
            end
            $fclose(fd);
            if (patterns.size() == 0)
            begin
                $display("ERROR: the pattern file holds no usable lines");
                aborted = 1'b1;
            end
        end
    endtask

    task automatic driveInstr(input pattern_t p);
        instr      = p.instr;
        rs1Data    = p.rs1Data;
        rs2Data    = p.rs2Data;
        pc         = p.pc;
        instrValid = 1'b1;
        strobeCount++;
    endtask

    task automatic compareResult(input int idx, input pattern_t p);
        string tag;
        tag = $sformatf("pattern %0d instr %h", idx, p.instr);
        // ALU value has no meaning for an illegal opcode
        if (!p.illegal)
            checkValue(out.aluResult, p.expAlu, {tag, " aluResult"});
        // rs2 always rides along as store data
        checkValue(out.writeData, p.rs2Data, {tag, " writeData"});
        checkValue(out.pcNext, p.expPcNext, {tag, " pcNext"});
        checkValue(32'(out.regWrite), 32'(p.regWrite), {tag, " regWrite"});
        checkValue(32'(out.memWrite), 32'(p.memWrite), {tag, " memWrite"});
        checkValue(32'(out.illegal), 32'(p.illegal), {tag, " illegal"});
        // write-back source only defined for supported opcodes
        if (!p.illegal)
            checkValue(32'(out.resultSrc), 32'(expectedResultSrc(p.instr)),
                       {tag, " resultSrc"});
    endtask

    initial
    begin
        int waited;
        int i;
        int total;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        rs1Data    = '0;
        rs2Data    = '0;
        pc         = '0;
        loadPatterns();
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        // idle after reset with nothing valid yet
        repeat (2)
        begin
            @(negedge clk);
            checkValue(32'(outValid), 32'd0, "outValid before the first strobe");
            checkValue(32'(out == '0), 32'd1, "out cleared by reset");
        end
        for (i = 0; i < patterns.size() && !aborted; i++)
        begin
            driveInstr(patterns[i]);
            @(negedge clk);
            // next strobe may follow right away
            instrValid = 1'b0;
            waited = 0;
            while (!outValid && waited < 4)
            begin
                @(negedge clk);
                waited++;
            end
            if (!outValid)
            begin
                $display("ERROR: no outValid within 4 cycles of strobe %0d", i);
                errorCount++;
                aborted = 1'b1;
            end
            else
                compareResult(i, patterns[i]);
            // one idle cycle after every third instruction
            if (!aborted && (i % 3) == 2)
            begin
                @(negedge clk);
                checkValue(32'(outValid), 32'd0, "outValid in an idle cycle");
            end
        end
        repeat (3) @(negedge clk);
        checkValue(validCount, strobeCount, "outValid cycles against strobes");
        total = errorCount + dut.uAsserts.assertFails;
        $display("checks %0d, check errors %0d, assertion failures %0d", checkCount,
                 errorCount, dut.uAsserts.assertFails);
        if (total == 0 && !aborted)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/rvDecodeExec_asserts.sv ====
// bound to rvDecodeExec and only meaningful with a clean synchronous reset at the start of the run
`timescale 1ns/10ps
`default_nettype none

module rvDecodeExec_asserts (
    input wire logic                clk,
    input wire logic                rstN,
    input wire logic                instrValid,
    input wire logic                outValid,
    input wire rvCorePkg::execOut_t out
);

    // failures seen so far, read by the testbench at the end
    int assertFails = 0;

    // reset clears the strobe on the next edge
    validLowInReset: assert property (@(posedge clk) !rstN |=> !outValid)
        else
        begin
            assertFails++;
            $error("outValid high while rstN is low");
        end

    // strobe out exactly one cycle after each strobe in and never otherwise
    validFollowsStrobe: assert property (@(posedge clk) disable iff (!rstN)
        outValid == $past(instrValid))
        else
        begin
            assertFails++;
            $error("outValid does not follow instrValid by one cycle");
        end

    // a store never writes the register file
    writesExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(out.regWrite && out.memWrite))
        else
        begin
            assertFails++;
            $error("regWrite and memWrite both high");
        end

    // illegal opcodes change no state
    illegalNoWrites: assert property (@(posedge clk) disable iff (!rstN)
        out.illegal |-> (!out.regWrite && !out.memWrite))
        else
        begin
            assertFails++;
            $error("write enable set on an illegal opcode");
        end

endmodule

bind rvDecodeExec rvDecodeExec_asserts uAsserts (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .outValid   (outValid),
    .out        (out)
);

`default_nettype wire

// ==== logic/rvDecodeExec.sv ====
// decode-execute slice taking one instruction per cycle with results one cycle after instrValid
`timescale 1ns/10ps
`default_nettype none

module rvDecodeExec (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire logic             instrValid,
    input  wire rvCorePkg::word_t instr,
    input  wire rvCorePkg::word_t rs1Data,
    input  wire rvCorePkg::word_t rs2Data,
    input  wire rvCorePkg::word_t pc,
    output logic                  outValid,
    output rvCorePkg::execOut_t   out
);

    wire rvCorePkg::immSrc_t  immSrc;
    wire rvCorePkg::ctrl_t    ctrl;
    wire rvCorePkg::aluCtrl_t aluCtrl;
    wire rvCorePkg::word_t    immExt;

    // opcode to immediate format
    immSrcDec uImmSrcDec (
        .op     (instr[6:0]),
        .immSrc (immSrc)
    );

    mainDecoder uMainDecoder (
        .op   (instr[6:0]),
        .ctrl (ctrl)
    );

    // funct3 in 14:12, funct7 bit 5 is instr[30], opcode bit 5 splits R from I
    aluDecoder uAluDecoder (
        .aluOp    (ctrl.aluOp),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .opb5     (instr[5]),
        .aluCtrl  (aluCtrl)
    );

    immExtend uImmExtend (
        .instr  (instr),
        .immSrc (immSrc),
        .immExt (immExt)
    );

    // only registered stage
    executeStage uExecuteStage (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .ctrl       (ctrl),
        .aluCtrl    (aluCtrl),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .pc         (pc),
        .immExt     (immExt),
        .outValid   (outValid),
        .out        (out)
    );

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
// one result register with no back-pressure so the consumer must take out in its outValid cycle
`timescale 1ns/10ps
`default_nettype none

module executeStage (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                instrValid,
    input  wire rvCorePkg::ctrl_t    ctrl,
    input  wire rvCorePkg::aluCtrl_t aluCtrl,
    input  wire rvCorePkg::word_t    rs1Data,
    input  wire rvCorePkg::word_t    rs2Data,
    input  wire rvCorePkg::word_t    pc,
    input  wire rvCorePkg::word_t    immExt,
    output logic                     outValid,
    output rvCorePkg::execOut_t      out
);

    rvCorePkg::word_t    srcB;
    rvCorePkg::word_t    aluOut;
    rvCorePkg::word_t    pcPlus4;
    rvCorePkg::word_t    pcTarget;
    logic                zero;
    logic                takeTarget;
    rvCorePkg::execOut_t nextOut;

    // operand B mux
    assign srcB = ctrl.aluSrcImm ? immExt : rs2Data;

    always_comb
    begin
        case (aluCtrl)
            rvCorePkg::ctrlAdd:
                aluOut = rs1Data + srcB;
            rvCorePkg::ctrlSub:
                aluOut = rs1Data - srcB;
            rvCorePkg::ctrlAnd:
                aluOut = rs1Data & srcB;
            rvCorePkg::ctrlOr:
                aluOut = rs1Data | srcB;
            rvCorePkg::ctrlPassB:
                aluOut = srcB;
            // signed compare
            rvCorePkg::ctrlSlt:
                aluOut = {31'b0, $signed(rs1Data) < $signed(srcB)};
            default:
                aluOut = rs1Data + srcB;
        endcase
    end

    // beq resolves on a zero difference
    assign zero = (aluOut == '0);

    assign pcPlus4  = pc + rvCorePkg::pcStep;
    assign pcTarget = pc + immExt;

    // jal always, beq only when equal
    assign takeTarget = ctrl.jump | (ctrl.branch & zero);

    always_comb
    begin
        nextOut.aluResult = aluOut;
        // jal returns the link address
        if (ctrl.resultSrc == rvCorePkg::resPcPlus4)
            nextOut.aluResult = pcPlus4;
        // store data is rs2 untouched
        nextOut.writeData = rs2Data;
        nextOut.pcNext    = takeTarget ? pcTarget : pcPlus4;
        nextOut.regWrite  = ctrl.regWrite;
        nextOut.memWrite  = ctrl.memWrite;
        nextOut.resultSrc = ctrl.resultSrc;
        nextOut.illegal   = ctrl.illegal;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
            out      <= '0;
        end
        else
        begin
            // strobe follows the input by one cycle
            outValid <= instrValid;
            // payload held between strobes
            if (instrValid)
                out <= nextOut;
        end
    end

endmodule

`default_nettype wire

// ==== logic/immExtend.sv ====
// combinational immediate builder for I S B J U formats with sign taken from instruction bit 31
`timescale 1ns/10ps
`default_nettype none

module immExtend (
    input  wire rvCorePkg::word_t   instr,
    input  wire rvCorePkg::immSrc_t immSrc,
    output rvCorePkg::word_t        immExt
);

    always_comb
    begin
        case (immSrc)
            // imm[11:0] in 31:20
            rvCorePkg::immI:
                immExt = {{20{instr[31]}}, instr[31:20]};
            // imm[11:5] in 31:25, imm[4:0] in 11:7
            rvCorePkg::immS:
                immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // halfword offset so bit 0 is zero
            rvCorePkg::immB:
                immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            // jal offset with its bits scrambled in the encoding
            rvCorePkg::immJ:
                immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            // low 12 bits zero
            rvCorePkg::immU:
                immExt = {instr[31:12], 12'b0};
            // unused codes
            default:
                immExt = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/aluDecoder.sv ====
// combinational ALU select where unsupported funct3 codes under aluFunct fall back to add
`timescale 1ns/10ps
`default_nettype none

module aluDecoder (
    input  wire rvCorePkg::aluOp_t  aluOp,
    input  wire rvCorePkg::funct3_t funct3,
    input  wire logic               funct7b5,
    input  wire logic               opb5,
    output rvCorePkg::aluCtrl_t     aluCtrl
);

    // sub only on R-type with funct7 bit 5 set
    // so addi with a negative immediate stays an add
    logic rtypeSub;

    assign rtypeSub = funct7b5 & opb5;

    always_comb
    begin
        case (aluOp)
            rvCorePkg::aluAdd:
                aluCtrl = rvCorePkg::ctrlAdd;
            rvCorePkg::aluSub:
                aluCtrl = rvCorePkg::ctrlSub;
            rvCorePkg::aluPass:
                aluCtrl = rvCorePkg::ctrlPassB;
            default:
            begin
                // R-type or I-type ALU
                case (funct3)
                    3'b000:
                        aluCtrl = rtypeSub ? rvCorePkg::ctrlSub : rvCorePkg::ctrlAdd;
                    // slt, slti
                    3'b010:
                        aluCtrl = rvCorePkg::ctrlSlt;
                    // or, ori
                    3'b110:
                        aluCtrl = rvCorePkg::ctrlOr;
                    // and, andi
                    3'b111:
                        aluCtrl = rvCorePkg::ctrlAnd;
                    default:
                        aluCtrl = rvCorePkg::ctrlAdd;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mainDecoder.sv ====
// combinational main control table where any opcode outside the subset sets illegal with no writes
`timescale 1ns/10ps
`default_nettype none

module mainDecoder (
    input  wire rvCorePkg::opcode_t op,
    output rvCorePkg::ctrl_t        ctrl
);

    always_comb
    begin
        // everything inactive unless the opcode says otherwise
        ctrl           = '0;
        ctrl.resultSrc = rvCorePkg::resAlu;
        ctrl.aluOp     = rvCorePkg::aluAdd;
        case (op)
            rvCorePkg::opLoad:
            begin
                // address is rs1 plus offset
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSrc = rvCorePkg::resMem;
            end
            rvCorePkg::opStore:
            begin
                // no register write on a store
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            rvCorePkg::opRtype:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rvCorePkg::aluFunct;
            end
            rvCorePkg::opItype:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = rvCorePkg::aluFunct;
            end
            rvCorePkg::opBranch:
            begin
                // compare by subtraction
                ctrl.branch = 1'b1;
                ctrl.aluOp  = rvCorePkg::aluSub;
            end
            rvCorePkg::opJal:
            begin
                // link value is pc + 4
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = rvCorePkg::resPcPlus4;
            end
            rvCorePkg::opLui:
            begin
                // immediate straight through the ALU
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = rvCorePkg::aluPass;
            end
            default:
            begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/immSrcDec.sv ====
// combinational map from opcode to immediate format where R-type and unknown opcodes give immI
`timescale 1ns/10ps
`default_nettype none

module immSrcDec (
    input  wire rvCorePkg::opcode_t op,
    output rvCorePkg::immSrc_t      immSrc
);

    always_comb
    begin
        case (op)
            // loads use the I format
            rvCorePkg::opLoad:
                immSrc = rvCorePkg::immI;
            // store offset split over two fields
            rvCorePkg::opStore:
                immSrc = rvCorePkg::immS;
            // immediate ALU ops
            rvCorePkg::opItype:
                immSrc = rvCorePkg::immI;
            // beq offset in halfwords
            rvCorePkg::opBranch:
                immSrc = rvCorePkg::immB;
            // jal 21-bit offset
            rvCorePkg::opJal:
                immSrc = rvCorePkg::immJ;
            // upper 20 bits
            rvCorePkg::opLui:
                immSrc = rvCorePkg::immU;
            // R-type has no immediate and garbage is flagged elsewhere
            default:
                immSrc = rvCorePkg::immI;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/rvCorePkg.sv ====
// RV32I subset only (lw sw R-type I-type beq jal lui) and every width is fixed by the ISA
`default_nettype none

package rvCorePkg;

    // widths with a meaning
    typedef logic [31:0] word_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // immediate format codes used by immSrcDec and immExtend
    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immSrc_t;

    // ALU class from the main decoder
    typedef enum logic [1:0] {
        aluAdd   = 2'b00,
        aluSub   = 2'b01,
        aluFunct = 2'b10,
        aluPass  = 2'b11
    } aluOp_t;

    // ALU operation select
    typedef enum logic [2:0] {
        ctrlAdd   = 3'b000,
        ctrlSub   = 3'b001,
        ctrlAnd   = 3'b010,
        ctrlOr    = 3'b011,
        ctrlPassB = 3'b100,
        ctrlSlt   = 3'b101
    } aluCtrl_t;

    // write-back source
    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultSrc_t;

    // major opcodes
    localparam opcode_t opLoad   = 7'b0000011;
    localparam opcode_t opStore  = 7'b0100011;
    localparam opcode_t opRtype  = 7'b0110011;
    localparam opcode_t opItype  = 7'b0010011;
    localparam opcode_t opBranch = 7'b1100011;
    localparam opcode_t opJal    = 7'b1101111;
    localparam opcode_t opLui    = 7'b0110111;

    // sequential pc step
    localparam word_t pcStep = 32'd4;

    // main decoder controls
    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       aluSrcImm;
        logic       branch;
        logic       jump;
        resultSrc_t resultSrc;
        aluOp_t     aluOp;
        logic       illegal;
    } ctrl_t;

    // registered execute result
    typedef struct packed {
        word_t      aluResult;
        word_t      writeData;
        word_t      pcNext;
        logic       regWrite;
        logic       memWrite;
        resultSrc_t resultSrc;
        logic       illegal;
    } execOut_t;

endpackage

`default_nettype wire
